// ==== dv/calc_ref.svh ====
`ifndef CALC_REF_SVH
`define CALC_REF_SVH

// segment pattern of one glyph code
function automatic seg_t glyph_segs(input glyph_t g);
    if (g < 5'd16) begin
        return SEG_HEX[g[3:0]];
    end
    if (g == GLYPH_MINUS) begin
        return SEG_MINUS;
    end
    return SEG_BLANK;
endfunction

// true signed sum (operator 1) or difference (operator 2)
function automatic int signed_result(input op_sel_t op, input operand_t a, input operand_t b);
    int sa;
    int sb;
    sa = $signed(a);
    sb = $signed(b);
    return (op == 2'd0) ? sa + sb : sa - sb;
endfunction

function automatic operand_t alu_result(input calc_type_t t, input op_sel_t op,
                                        input operand_t a, input operand_t b);
    int   amt;
    logic at;
    logic bt;
    logic r;
    amt = b;
    at = (a != 8'h00);
    bt = (b != 8'h00);
    if (t == TYPE_SHIFT) begin
        case (op)
            2'd1:    return (amt >= 8) ? {8{a[7]}} : operand_t'($signed(a) >>> amt);
            2'd3:    return (amt >= 8) ? 8'h00 : operand_t'(a >> amt);
            default: return (amt >= 8) ? 8'h00 : operand_t'(a << amt);   // both left shifts
        endcase
    end
    if (t == TYPE_BITWISE) begin
        case (op)
            2'd0:    return a & b;
            2'd1:    return a | b;
            2'd2:    return ~a;
            default: return a ^ b;
        endcase
    end
    if (t == TYPE_LOGIC) begin
        case (op)
            2'd0:    r = at && bt;
            2'd1:    r = at || bt;
            2'd2:    r = !at;
            default: r = at ^ bt;
        endcase
        return {8{r}};
    end
    return 8'h00;
endfunction

function automatic operand_t predict_leds(input logic entered, input calc_type_t t,
                                          input op_sel_t op, input calc_step_t step,
                                          input operand_t a, input operand_t b,
                                          input operand_t sw);
    if (!entered) begin
        return 8'h00;
    end
    if (step == STEP_LOAD_A || step == STEP_LOAD_B) begin
        return sw;   // live operand view
    end
    if (step == STEP_SHOW) begin
        return alu_result(t, op, a, b);
    end
    return 8'h00;
endfunction

// glyph expected on digit 1..8
function automatic glyph_t predict_glyph(input int digit, input logic entered,
                                         input calc_type_t t, input op_sel_t op,
                                         input calc_step_t step, input operand_t a,
                                         input operand_t b);
    int res;
    int mag;
    res = signed_result(op, a, b);
    mag = (res < 0) ? -res : res;
    if (!entered) begin
        return (digit == 1) ? glyph_t'(t) : GLYPH_BLANK;
    end
    if (step == STEP_SHOW && t == TYPE_CONVERT) begin
        case (digit)
            1:       return glyph_t'(a / 64);   // octal
            2:       return glyph_t'((a / 8) % 8);
            3:       return glyph_t'(a % 8);
            4:       return glyph_t'(a / 100);  // decimal
            5:       return glyph_t'((a / 10) % 10);
            6:       return glyph_t'(a % 10);
            7:       return glyph_t'(a / 16);   // hex
            default: return glyph_t'(a % 16);
        endcase
    end
    if (digit == 1) begin
        return glyph_t'(t);
    end
    if (digit == 2) begin
        return glyph_t'(op + 1);
    end
    if (digit == 3 && (step == STEP_LOAD_A || step == STEP_LOAD_B)) begin
        return glyph_t'(10);   // letter a
    end
    if (digit == 4 && step == STEP_LOAD_B) begin
        return glyph_t'(11);   // letter b
    end
    if (digit >= 5 && step == STEP_SHOW && t == TYPE_SIGNED) begin
        case (digit)
            5:       return (res < 0) ? GLYPH_MINUS : glyph_t'(0);
            6:       return glyph_t'(mag / 100);
            7:       return glyph_t'((mag / 10) % 10);
            default: return glyph_t'(mag % 10);
        endcase
    end
    return GLYPH_BLANK;
endfunction

`endif

// ==== dv/calc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module calc_tb;

    import calc_pkg::*;
    import seg_pkg::*;

    `include "calc_ref.svh"

    localparam int BTN_EXIT    = 0;
    localparam int BTN_CONFIRM = 1;
    localparam int BTN_SELECT  = 2;
    localparam logic [31:0] SEED = 32'h929044dc;
    // presses per test, a switch change counted as one press
    localparam int PRESS_COUNT = 16 + 20 * 4 + 3 + 16 * 7 + 3 * (3 + 8 * 10) + 22;
    localparam int CYCLE_LIMIT = PRESS_COUNT * 12 + 200;

    localparam operand_t PAIR_A [6] = '{8'h5a, 8'h96, 8'hc3, 8'h00, 8'hff, 8'h00};
    localparam operand_t PAIR_B [6] = '{8'h03, 8'h08, 8'hc8, 8'h00, 8'h00, 8'h37};

    logic       clk;
    logic       rst_n;
    logic       confirm;
    logic       exit_btn;
    logic       select;
    operand_t   switches;
    logic       type_entered;
    seg_t       digit_segs_1;
    seg_t       digit_segs_2;
    seg_t       digit_segs_3;
    seg_t       digit_segs_4;
    seg_t       digit_segs_5;
    seg_t       digit_segs_6;
    seg_t       digit_segs_7;
    seg_t       digit_segs_8;
    operand_t   leds;

    // expected calculator state
    logic        exp_entered;
    calc_type_t  exp_type;
    op_sel_t     exp_op;
    calc_step_t  exp_step;
    operand_t    exp_a;
    operand_t    exp_b;

    logic [31:0] rand_state;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    calc_top u_calc_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .confirm      (confirm),
        .exit_btn     (exit_btn),
        .select       (select),
        .switches     (switches),
        .type_entered (type_entered),
        .digit_segs_1 (digit_segs_1),
        .digit_segs_2 (digit_segs_2),
        .digit_segs_3 (digit_segs_3),
        .digit_segs_4 (digit_segs_4),
        .digit_segs_5 (digit_segs_5),
        .digit_segs_6 (digit_segs_6),
        .digit_segs_7 (digit_segs_7),
        .digit_segs_8 (digit_segs_8),
        .leds         (leds)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("checks %0d, mismatches %0d", checks, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic operand_t rand_operand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;   // lcg step
        return rand_state[23:16];
    endfunction

    function automatic seg_t actual_segs(input int digit);
        case (digit)
            1:       return digit_segs_1;
            2:       return digit_segs_2;
            3:       return digit_segs_3;
            4:       return digit_segs_4;
            5:       return digit_segs_5;
            6:       return digit_segs_6;
            7:       return digit_segs_7;
            default: return digit_segs_8;
        endcase
    endfunction

    function automatic int op_count(input calc_type_t t);
        if (t == TYPE_CONVERT) begin
            return OP_COUNT_CONVERT;
        end
        return (t == TYPE_SIGNED) ? OP_COUNT_SIGNED : OP_COUNT_OTHER;
    endfunction

    // state change that one press should cause
    function automatic void advance_model(input int which);
        if (which == BTN_EXIT) begin
            exp_entered = 1'b0;
            exp_op = 2'd0;
            exp_step = STEP_IDLE;
        end else if (which == BTN_CONFIRM && !exp_entered) begin
            exp_entered = 1'b1;
            exp_op = 2'd0;
            exp_step = STEP_IDLE;
        end else if (which == BTN_CONFIRM) begin
            case (exp_step)
                STEP_IDLE:   exp_step = STEP_LOAD_A;
                STEP_LOAD_A: exp_step = (exp_type == TYPE_CONVERT) ? STEP_SHOW : STEP_LOAD_B;
                STEP_LOAD_B: exp_step = STEP_SHOW;
                default:     exp_step = STEP_IDLE;
            endcase
        end else if (!exp_entered) begin
            exp_type = (exp_type == TYPE_LOGIC) ? TYPE_CONVERT : calc_type_t'(exp_type + 1);
        end else begin
            exp_op = op_sel_t'((exp_op + 1) % op_count(exp_type));
        end
        if (exp_step == STEP_LOAD_A) begin
            exp_a = switches;
        end
        if (exp_step == STEP_LOAD_B) begin
            exp_b = switches;
        end
    endfunction

    task automatic check_eq(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_outputs(input string name);
        seg_t     segs_exp;
        operand_t leds_exp;
        for (int d = 1; d <= NUM_DIGITS; d++) begin
            segs_exp = glyph_segs(predict_glyph(d, exp_entered, exp_type, exp_op,
                                                exp_step, exp_a, exp_b));
            check_eq($sformatf("%s digit %0d", name, d), segs_exp, actual_segs(d));
        end
        leds_exp = predict_leds(exp_entered, exp_type, exp_op, exp_step,
                                exp_a, exp_b, switches);
        check_eq({name, " leds"}, leds_exp, leds);
        check_eq({name, " type_entered"}, exp_entered, type_entered);
    endtask

    // 3 cycles high, then 8 for the result to settle
    task automatic press(input int which);
        @(negedge clk);
        case (which)
            BTN_EXIT:    exit_btn = 1'b1;
            BTN_CONFIRM: confirm = 1'b1;
            default:     select = 1'b1;
        endcase
        repeat (3) @(negedge clk);
        exit_btn = 1'b0;
        confirm = 1'b0;
        select = 1'b0;
        repeat (8) @(negedge clk);
        advance_model(which);
    endtask

    task automatic set_switches(input operand_t value);
        @(negedge clk);
        switches = value;
        if (exp_step == STEP_LOAD_A && exp_entered) begin
            exp_a = value;
        end
        if (exp_step == STEP_LOAD_B && exp_entered) begin
            exp_b = value;
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic goto_type(input calc_type_t t);
        while (exp_type != t) begin
            press(BTN_SELECT);
        end
    endtask

    task automatic convert_case(input operand_t a);
        set_switches(a);
        press(BTN_CONFIRM);
        press(BTN_CONFIRM);
        check_outputs("convert");
        press(BTN_CONFIRM);
    endtask

    task automatic signed_case(input operand_t a, input operand_t b, input op_sel_t op);
        while (exp_op != op) begin
            press(BTN_SELECT);
        end
        set_switches(a);
        press(BTN_CONFIRM);
        press(BTN_CONFIRM);
        set_switches(b);
        press(BTN_CONFIRM);
        check_outputs("signed");
        press(BTN_CONFIRM);
    endtask

    // loads a pair and walks all four operators in show
    task automatic alu_pair(input operand_t a, input operand_t b);
        set_switches(a);
        press(BTN_CONFIRM);
        press(BTN_CONFIRM);
        set_switches(b);
        press(BTN_CONFIRM);
        check_outputs("alu op 1");
        repeat (4) begin
            press(BTN_SELECT);
            check_outputs("alu op select");
        end
        press(BTN_CONFIRM);
    endtask

    initial begin
        operand_t ra;
        operand_t rb;
        clk = 1'b0;
        rst_n = 1'b0;
        confirm = 1'b0;
        exit_btn = 1'b0;
        select = 1'b0;
        switches = 8'h00;
        rand_state = SEED;
        exp_entered = 1'b0;
        exp_type = TYPE_CONVERT;
        exp_op = 2'd0;
        exp_step = STEP_IDLE;
        exp_a = 8'h00;
        exp_b = 8'h00;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_outputs("reset");

        repeat (6) begin
            press(BTN_SELECT);
            check_outputs("browse select");
        end
        press(BTN_CONFIRM);
        check_outputs("enter signed");
        repeat (2) begin
            press(BTN_SELECT);
            check_outputs("signed op wrap");
        end
        press(BTN_EXIT);
        goto_type(TYPE_CONVERT);
        press(BTN_CONFIRM);
        press(BTN_SELECT);
        check_outputs("convert op wrap");

        convert_case(8'h00);
        convert_case(8'hff);
        repeat (18) convert_case(rand_operand());
        press(BTN_EXIT);
        goto_type(TYPE_SIGNED);
        press(BTN_CONFIRM);

        signed_case(8'h7f, 8'h01, 2'd0);   // +128
        signed_case(8'h80, 8'h01, 2'd1);   // -129
        signed_case(8'h80, 8'h80, 2'd0);   // -256
        signed_case(8'h7f, 8'h80, 2'd1);   // +255
        signed_case(8'h00, 8'h00, 2'd0);
        signed_case(8'h05, 8'h09, 2'd1);
        for (int i = 0; i < 10; i++) begin
            ra = rand_operand();
            rb = rand_operand();
            signed_case(ra, rb, op_sel_t'(i % 2));
        end

        for (int t = 3; t <= 5; t++) begin
            press(BTN_EXIT);
            goto_type(calc_type_t'(t));
            press(BTN_CONFIRM);
            for (int p = 0; p < 6; p++) begin
                alu_pair(PAIR_A[p], PAIR_B[p]);
            end
            repeat (2) begin
                ra = rand_operand();
                rb = (exp_type == TYPE_SHIFT) ? rand_operand() % 8'd12 : rand_operand();
                alu_pair(ra, rb);
            end
        end

        // live view and exit from every step
        press(BTN_EXIT);
        goto_type(TYPE_SIGNED);
        press(BTN_CONFIRM);
        press(BTN_SELECT);
        check_outputs("signed op 2");
        press(BTN_CONFIRM);
        check_outputs("load a");
        repeat (2) begin
            set_switches(rand_operand());
            check_outputs("live a");
        end
        press(BTN_EXIT);
        check_outputs("exit load a");
        press(BTN_CONFIRM);
        check_outputs("reenter");
        press(BTN_CONFIRM);
        press(BTN_CONFIRM);
        check_outputs("load b");
        repeat (2) begin
            set_switches(rand_operand());
            check_outputs("live b");
        end
        press(BTN_EXIT);
        check_outputs("exit load b");
        press(BTN_CONFIRM);
        repeat (3) press(BTN_CONFIRM);
        check_outputs("show");
        press(BTN_EXIT);
        check_outputs("exit show");
        press(BTN_CONFIRM);
        check_outputs("reenter");
        press(BTN_EXIT);
        check_outputs("exit idle");

        $display("checks %0d, mismatches %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+dv
verilog/calc_pkg.sv
verilog/seg_pkg.sv
verilog/button_pulse.sv
verilog/calc_control.sv
verilog/calc_alu.sv
verilog/result_formatter.sv
verilog/seg_digit_encoder.sv
verilog/calc_top.sv
dv/calc_tb.sv

// ==== verilog/button_pulse.sv ====
`timescale 1ns/1ns
`default_nettype none

module button_pulse (
    input  logic clk,
    input  logic rst_n,
    input  logic confirm,
    input  logic exit_btn,
    input  logic select,
    output logic confirm_pulse,
    output logic exit_pulse,
    output logic select_pulse
);

    logic [2:0] btn_raw;    // {exit, confirm, select}
    logic [2:0] btn_meta;
    logic [2:0] btn_sync;
    logic [2:0] btn_seen;   // level of the previous cycle
    logic [2:0] pulse_q;

    assign btn_raw = {exit_btn, confirm, select};

    // keeps sampling through reset, so a button held across reset
    // is already seen when reset ends and gives no pulse
    always_ff @(posedge clk) begin
        btn_meta <= btn_raw;
        btn_sync <= btn_meta;
        btn_seen <= btn_sync;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pulse_q <= '0;
        end else begin
            pulse_q <= btn_sync & ~btn_seen;   // rising edge only
        end
    end

    assign exit_pulse    = pulse_q[2];
    assign confirm_pulse = pulse_q[1];
    assign select_pulse  = pulse_q[0];

endmodule

`default_nettype wire

// ==== verilog/calc_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module calc_alu (
    input  calc_pkg::calc_type_t calc_type,
    input  calc_pkg::op_sel_t    op_sel,
    input  calc_pkg::operand_t   operand_a,
    input  calc_pkg::operand_t   operand_b,
    output calc_pkg::operand_t   alu_leds,
    output logic                 signed_neg,
    output logic [8:0]           signed_mag
);

    import calc_pkg::*;

    logic signed [8:0] a_wide;
    logic signed [8:0] b_wide;
    logic signed [8:0] signed_res;   // true sum or difference
    logic signed [7:0] a_signed;
    logic              a_true;
    logic              b_true;
    operand_t          shift_res;
    operand_t          bitwise_res;
    operand_t          logic_res;

    assign a_wide   = {operand_a[7], operand_a};   // sign extend
    assign b_wide   = {operand_b[7], operand_b};
    assign a_signed = operand_a;

    // operator 1 adds, operator 2 subtracts
    assign signed_res = (op_sel == 2'd1) ? a_wide - b_wide : a_wide + b_wide;
    assign signed_neg = signed_res[8];
    assign signed_mag = signed_neg ? -signed_res : signed_res;   // up to 256

    // shift amount is all of b, so 8 and above flush the operand
    always_comb begin
        case (op_sel)
            2'd0:    shift_res = a_signed <<< operand_b;
            2'd1:    shift_res = a_signed >>> operand_b;   // sign fill
            2'd2:    shift_res = operand_a << operand_b;
            default: shift_res = operand_a >> operand_b;
        endcase
    end

    always_comb begin
        case (op_sel)
            2'd0:    bitwise_res = operand_a & operand_b;
            2'd1:    bitwise_res = operand_a | operand_b;
            2'd2:    bitwise_res = ~operand_a;
            default: bitwise_res = operand_a ^ operand_b;
        endcase
    end

    assign a_true = |operand_a;
    assign b_true = |operand_b;

    always_comb begin
        case (op_sel)
            2'd0:    logic_res = {8{a_true & b_true}};
            2'd1:    logic_res = {8{a_true | b_true}};
            2'd2:    logic_res = {8{~a_true}};
            default: logic_res = {8{a_true ^ b_true}};
        endcase
    end

    always_comb begin
        case (calc_type)
            TYPE_SHIFT:   alu_leds = shift_res;
            TYPE_BITWISE: alu_leds = bitwise_res;
            TYPE_LOGIC:   alu_leds = logic_res;
            default:      alu_leds = '0;   // convert and signed use the digits
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/calc_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module calc_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 confirm_pulse,
    input  logic                 exit_pulse,
    input  logic                 select_pulse,
    input  calc_pkg::operand_t   switches,
    output logic                 type_entered,
    output calc_pkg::calc_type_t calc_type,
    output calc_pkg::op_sel_t    op_sel,
    output calc_pkg::calc_step_t step,
    output calc_pkg::operand_t   operand_a,
    output calc_pkg::operand_t   operand_b
);

    import calc_pkg::*;

    op_sel_t    op_last;     // highest operator of the current type
    calc_type_t type_next;
    calc_step_t step_next;

    always_comb begin
        case (calc_type)
            TYPE_CONVERT: op_last = op_sel_t'(OP_COUNT_CONVERT - 1);
            TYPE_SIGNED:  op_last = op_sel_t'(OP_COUNT_SIGNED - 1);
            default:      op_last = op_sel_t'(OP_COUNT_OTHER - 1);
        endcase
    end

    always_comb begin
        case (calc_type)
            TYPE_CONVERT: type_next = TYPE_SIGNED;
            TYPE_SIGNED:  type_next = TYPE_SHIFT;
            TYPE_SHIFT:   type_next = TYPE_BITWISE;
            TYPE_BITWISE: type_next = TYPE_LOGIC;
            default:      type_next = TYPE_CONVERT;   // 5 wraps to 1
        endcase
    end

    always_comb begin
        case (step)
            STEP_IDLE: begin
                step_next = STEP_LOAD_A;
            end
            STEP_LOAD_A: begin
                if (calc_type == TYPE_CONVERT) begin
                    step_next = STEP_SHOW;   // single operand
                end else begin
                    step_next = STEP_LOAD_B;
                end
            end
            STEP_LOAD_B: begin
                step_next = STEP_SHOW;
            end
            default: begin
                step_next = STEP_IDLE;
            end
        endcase
    end

    // exit wins over confirm, confirm over select
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            type_entered <= 1'b0;
            calc_type    <= TYPE_CONVERT;
            op_sel       <= '0;
            step         <= STEP_IDLE;
        end else if (exit_pulse) begin
            type_entered <= 1'b0;   // no effect while browsing
            op_sel       <= '0;
            step         <= STEP_IDLE;
        end else if (confirm_pulse) begin
            if (type_entered) begin
                step <= step_next;
            end else begin
                type_entered <= 1'b1;
                op_sel       <= '0;
                step         <= STEP_IDLE;
            end
        end else if (select_pulse) begin
            if (!type_entered) begin
                calc_type <= type_next;
            end else if (op_sel == op_last) begin
                op_sel <= '0;
            end else begin
                op_sel <= op_sel + 2'd1;
            end
        end
    end

    // operands track the switches while their load step is active
    always_ff @(posedge clk) begin
        if (step == STEP_LOAD_A) begin
            operand_a <= switches;
        end
        if (step == STEP_LOAD_B) begin
            operand_b <= switches;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    typedef logic [7:0] operand_t;   // operand or led pattern
    typedef logic [1:0] op_sel_t;    // operator index, shown plus one

    // the encoding is also the number shown on digit 1
    typedef enum logic [2:0] {
        TYPE_CONVERT = 3'd1,   // base conversion
        TYPE_SIGNED  = 3'd2,   // signed add/sub
        TYPE_SHIFT   = 3'd3,
        TYPE_BITWISE = 3'd4,
        TYPE_LOGIC   = 3'd5
    } calc_type_t;

    typedef enum logic [1:0] {
        STEP_IDLE   = 2'd0,
        STEP_LOAD_A = 2'd1,
        STEP_LOAD_B = 2'd2,    // skipped by convert
        STEP_SHOW   = 2'd3
    } calc_step_t;

    // operators per type
    localparam int OP_COUNT_CONVERT = 1;
    localparam int OP_COUNT_SIGNED  = 2;
    localparam int OP_COUNT_OTHER   = 4;   // shift, bitwise, logic

endpackage

`default_nettype wire

// ==== verilog/calc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module calc_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               confirm,
    input  logic               exit_btn,
    input  logic               select,
    input  calc_pkg::operand_t switches,
    output logic               type_entered,
    output seg_pkg::seg_t      digit_segs_1,
    output seg_pkg::seg_t      digit_segs_2,
    output seg_pkg::seg_t      digit_segs_3,
    output seg_pkg::seg_t      digit_segs_4,
    output seg_pkg::seg_t      digit_segs_5,
    output seg_pkg::seg_t      digit_segs_6,
    output seg_pkg::seg_t      digit_segs_7,
    output seg_pkg::seg_t      digit_segs_8,
    output calc_pkg::operand_t leds
);

    import calc_pkg::*;
    import seg_pkg::*;

    logic       confirm_pulse;
    logic       exit_pulse;
    logic       select_pulse;
    calc_type_t calc_type;
    op_sel_t    op_sel;
    calc_step_t step;
    operand_t   operand_a;
    operand_t   operand_b;
    operand_t   alu_leds;
    logic       signed_neg;
    logic [8:0] signed_mag;
    glyph_t     glyphs [NUM_DIGITS];
    seg_t       segs [NUM_DIGITS];

    button_pulse u_button_pulse (
        .clk           (clk),
        .rst_n         (rst_n),
        .confirm       (confirm),
        .exit_btn      (exit_btn),
        .select        (select),
        .confirm_pulse (confirm_pulse),
        .exit_pulse    (exit_pulse),
        .select_pulse  (select_pulse)
    );

    calc_control u_calc_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .confirm_pulse (confirm_pulse),
        .exit_pulse    (exit_pulse),
        .select_pulse  (select_pulse),
        .switches      (switches),
        .type_entered  (type_entered),
        .calc_type     (calc_type),
        .op_sel        (op_sel),
        .step          (step),
        .operand_a     (operand_a),
        .operand_b     (operand_b)
    );

    calc_alu u_calc_alu (
        .calc_type  (calc_type),
        .op_sel     (op_sel),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_leds   (alu_leds),
        .signed_neg (signed_neg),
        .signed_mag (signed_mag)
    );

    result_formatter u_result_formatter (
        .clk          (clk),
        .rst_n        (rst_n),
        .type_entered (type_entered),
        .calc_type    (calc_type),
        .op_sel       (op_sel),
        .step         (step),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .switches     (switches),
        .alu_leds     (alu_leds),
        .signed_neg   (signed_neg),
        .signed_mag   (signed_mag),
        .glyph_1      (glyphs[0]),
        .glyph_2      (glyphs[1]),
        .glyph_3      (glyphs[2]),
        .glyph_4      (glyphs[3]),
        .glyph_5      (glyphs[4]),
        .glyph_6      (glyphs[5]),
        .glyph_7      (glyphs[6]),
        .glyph_8      (glyphs[7]),
        .leds         (leds)
    );

    // one registered encoder per digit
    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
        seg_digit_encoder u_seg_digit_encoder (
            .clk   (clk),
            .rst_n (rst_n),
            .glyph (glyphs[i]),
            .segs  (segs[i])
        );
    end

    assign digit_segs_1 = segs[0];
    assign digit_segs_2 = segs[1];
    assign digit_segs_3 = segs[2];
    assign digit_segs_4 = segs[3];
    assign digit_segs_5 = segs[4];
    assign digit_segs_6 = segs[5];
    assign digit_segs_7 = segs[6];
    assign digit_segs_8 = segs[7];

endmodule

`default_nettype wire

// ==== verilog/result_formatter.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_formatter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 type_entered,
    input  calc_pkg::calc_type_t calc_type,
    input  calc_pkg::op_sel_t    op_sel,
    input  calc_pkg::calc_step_t step,
    input  calc_pkg::operand_t   operand_a,
    input  calc_pkg::operand_t   operand_b,
    input  calc_pkg::operand_t   switches,
    input  calc_pkg::operand_t   alu_leds,
    input  logic                 signed_neg,
    input  logic [8:0]           signed_mag,
    output seg_pkg::glyph_t      glyph_1,
    output seg_pkg::glyph_t      glyph_2,
    output seg_pkg::glyph_t      glyph_3,
    output seg_pkg::glyph_t      glyph_4,
    output seg_pkg::glyph_t      glyph_5,
    output seg_pkg::glyph_t      glyph_6,
    output seg_pkg::glyph_t      glyph_7,
    output seg_pkg::glyph_t      glyph_8,
    output calc_pkg::operand_t   leds
);

    import calc_pkg::*;
    import seg_pkg::*;

    glyph_t glyph [NUM_DIGITS];   // index 0 is digit 1
    glyph_t type_glyph;
    glyph_t op_glyph;

    function automatic glyph_t hex_glyph(input logic [3:0] value);
        return {1'b0, value};
    endfunction

    // one decimal digit of value at the given place (1, 10, 100)
    function automatic glyph_t dec_glyph(input logic [8:0] value, input int unsigned place);
        return hex_glyph(4'((value / place) % 10));
    endfunction

    assign type_glyph = hex_glyph({1'b0, calc_type});
    assign op_glyph   = hex_glyph({2'b00, op_sel} + 4'd1);   // shown from 1

    always_comb begin
        glyph = '{default: GLYPH_BLANK};
        if (!type_entered) begin
            glyph[0] = type_glyph;
        end else if (step == STEP_SHOW && calc_type == TYPE_CONVERT) begin
            glyph[0] = hex_glyph({2'b00, operand_a[7:6]});   // octal
            glyph[1] = hex_glyph({1'b0, operand_a[5:3]});
            glyph[2] = hex_glyph({1'b0, operand_a[2:0]});
            glyph[3] = dec_glyph({1'b0, operand_a}, 100);    // decimal
            glyph[4] = dec_glyph({1'b0, operand_a}, 10);
            glyph[5] = dec_glyph({1'b0, operand_a}, 1);
            glyph[6] = hex_glyph(operand_a[7:4]);            // hex
            glyph[7] = hex_glyph(operand_a[3:0]);
        end else begin
            glyph[0] = type_glyph;
            glyph[1] = op_glyph;
            if (step == STEP_LOAD_A || step == STEP_LOAD_B) begin
                glyph[2] = hex_glyph(4'hA);   // prompt for a
            end
            if (step == STEP_LOAD_B) begin
                glyph[3] = hex_glyph(4'hB);
            end
            if (step == STEP_SHOW && calc_type == TYPE_SIGNED) begin
                glyph[4] = signed_neg ? GLYPH_MINUS : hex_glyph(4'd0);
                glyph[5] = dec_glyph(signed_mag, 100);
                glyph[6] = dec_glyph(signed_mag, 10);
                glyph[7] = dec_glyph(signed_mag, 1);
            end
        end
    end

    assign glyph_1 = glyph[0];
    assign glyph_2 = glyph[1];
    assign glyph_3 = glyph[2];
    assign glyph_4 = glyph[3];
    assign glyph_5 = glyph[4];
    assign glyph_6 = glyph[5];
    assign glyph_7 = glyph[6];
    assign glyph_8 = glyph[7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (type_entered && (step == STEP_LOAD_A || step == STEP_LOAD_B)) begin
            leds <= switches;   // live view of the operand being loaded
        end else if (type_entered && step == STEP_SHOW) begin
            leds <= alu_leds;   // zero for convert and signed
        end else begin
            leds <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/seg_digit_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module seg_digit_encoder (
    input  logic            clk,
    input  logic            rst_n,
    input  seg_pkg::glyph_t glyph,
    output seg_pkg::seg_t   segs
);

    import seg_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            segs <= SEG_BLANK;
        end else if (glyph < GLYPH_BLANK) begin
            segs <= SEG_HEX[glyph[3:0]];   // hex digit
        end else if (glyph == GLYPH_MINUS) begin
            segs <= SEG_MINUS;
        end else begin
            segs <= SEG_BLANK;   // blank and unused codes
        end
    end

endmodule

`default_nettype wire

// ==== verilog/seg_pkg.sv ====
`default_nettype none

package seg_pkg;

    typedef logic [4:0] glyph_t;   // 0..15 hex, then specials
    typedef logic [7:0] seg_t;     // a..g plus dot

    localparam int NUM_DIGITS = 8;

    localparam glyph_t GLYPH_BLANK = 5'd16;
    localparam glyph_t GLYPH_MINUS = 5'd17;

    localparam seg_t SEG_BLANK = 8'b0000_0000;
    localparam seg_t SEG_MINUS = 8'b0000_0010;   // middle bar only

    localparam seg_t SEG_HEX [16] = '{
        8'b1111_1100,   // 0
        8'b0110_0000,   // 1
        8'b1101_1010,   // 2
        8'b1111_0010,   // 3
        8'b0110_0110,   // 4
        8'b1011_0110,   // 5
        8'b1011_1110,   // 6
        8'b1110_0000,   // 7
        8'b1111_1110,   // 8
        8'b1111_0110,   // 9
        8'b1110_1110,   // a
        8'b0011_1110,   // b
        8'b1001_1100,   // c
        8'b0111_1010,   // d
        8'b1001_1110,   // e
        8'b1000_1110    // f
    };

endpackage

`default_nettype wire
